//--- hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // 5-bit function codes
    typedef enum logic [4:0] {
        FUNC_SLL  = 5'b00000,
        FUNC_SRL  = 5'b00001,
        FUNC_SRA  = 5'b00010,
        FUNC_MFHI = 5'b00100,
        FUNC_MFLO = 5'b00101,
        FUNC_MUL  = 5'b01000, // signed full product to hi/lo
        FUNC_MULU = 5'b01001,
        FUNC_DIV  = 5'b01010, // quotient to lo and remainder to hi
        FUNC_DIVU = 5'b01011,
        FUNC_ADD  = 5'b01100,
        FUNC_ADDU = 5'b01101,
        FUNC_SUB  = 5'b01110,
        FUNC_SUBU = 5'b01111,
        FUNC_AND  = 5'b10000,
        FUNC_OR   = 5'b10001,
        FUNC_XOR  = 5'b10010,
        FUNC_NOR  = 5'b10011,
        FUNC_SLT  = 5'b11000,
        FUNC_SLTU = 5'b11001,
        FUNC_LU   = 5'b11010, // rt into upper half
        FUNC_BEQ  = 5'b11100,
        FUNC_BNE  = 5'b11101,
        FUNC_BLT  = 5'b11110,
        FUNC_BLEQ = 5'b11111
    } alu_func_t;

    // codes not listed above are unknown and only produce done

    // register index for 32 registers
    typedef logic [4:0] reg_idx_t;

    // sign fix-up cycle after the WIDTH subtract-and-shift steps
    localparam int DIV_CYCLES_EXTRA = 1;

endpackage

`default_nettype wire

//--- hw/muldiv_if.sv
`timescale 1ns/1ns
`default_nettype none

interface muldiv_if #(
    parameter int WIDTH = 32
);

    logic                 start; // one cycle strobe
    alu_pkg::alu_func_t   func;
    logic [WIDTH-1:0]     rs;
    logic [WIDTH-1:0]     rt;
    logic                 busy;  // divide in flight
    logic                 done;  // divide finishing this cycle
    logic [WIDTH-1:0]     hi;
    logic [WIDTH-1:0]     lo;

    // execute core side
    modport core (
        output start, func, rs, rt,
        input  busy, done, hi, lo
    );

    // multiply and divide side
    modport unit (
        input  start, func, rs, rt,
        output busy, done, hi, lo
    );

endinterface

`default_nettype wire

//--- hw/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file #(
    parameter int WIDTH = 32
) (
    input  logic              clk,
    input  logic              reset,
    input  alu_pkg::reg_idx_t rs_idx,
    input  alu_pkg::reg_idx_t rt_idx,
    output logic [WIDTH-1:0]  rs_data,
    output logic [WIDTH-1:0]  rt_data,
    input  logic              write,
    input  alu_pkg::reg_idx_t write_idx,
    input  logic [WIDTH-1:0]  write_data
);

    localparam int NUM_REGS = 2 ** $bits(alu_pkg::reg_idx_t);

    logic [WIDTH-1:0] regs [NUM_REGS];

    // register zero is cleared by reset and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write && (write_idx != '0)) begin
            regs[write_idx] <= write_data;
        end
    end

    // combinational reads, a write shows up after the edge
    assign rs_data = regs[rs_idx];
    assign rt_data = regs[rt_idx];

    // an X index would corrupt an unknown register
    a_write_idx_known : assert property (
        @(posedge clk) disable iff (reset)
        write |-> !$isunknown(write_idx)
    ) else $error("register_file: write with unknown index");

endmodule

`default_nettype wire

//--- hw/arithmetic_logic_unit.sv
`timescale 1ns/1ns
`default_nettype none

module arithmetic_logic_unit #(
    parameter int WIDTH = 32
) (
    input  alu_pkg::alu_func_t func,
    input  logic [WIDTH-1:0]   rs,
    input  logic [WIDTH-1:0]   rt,
    output logic [WIDTH-1:0]   rd,
    output logic               branch,
    output logic               writes_rd
);

    localparam int SHAMT_W = $clog2(WIDTH);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;

    assign shamt       = rt[SHAMT_W-1:0];        // low log2(WIDTH) bits only
    assign lt_signed   = $signed(rs) < $signed(rt);
    assign lt_unsigned = rs < rt;
    assign equal       = rs == rt;

    ////////////////////////////////////////////////////////////
    // function decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd        = '0;
        branch    = 1'b0;
        writes_rd = 1'b1;

        case (func)
            alu_pkg::FUNC_SLL: begin
                rd = rs << shamt;
            end
            alu_pkg::FUNC_SRL: begin
                rd = rs >> shamt;
            end
            alu_pkg::FUNC_SRA: begin
                rd = $signed(rs) >>> shamt;
            end
            alu_pkg::FUNC_MFHI, alu_pkg::FUNC_MFLO: begin
                rd = '0;                          // core picks hi/lo instead
            end
            alu_pkg::FUNC_ADD, alu_pkg::FUNC_ADDU: begin
                rd = rs + rt;                     // no overflow trap
            end
            alu_pkg::FUNC_SUB, alu_pkg::FUNC_SUBU: begin
                rd = rs - rt;
            end
            alu_pkg::FUNC_AND: begin
                rd = rs & rt;
            end
            alu_pkg::FUNC_OR: begin
                rd = rs | rt;
            end
            alu_pkg::FUNC_XOR: begin
                rd = rs ^ rt;
            end
            alu_pkg::FUNC_NOR: begin
                rd = ~(rs | rt);
            end
            alu_pkg::FUNC_SLT: begin
                rd = {{(WIDTH-1){1'b0}}, lt_signed};
            end
            alu_pkg::FUNC_SLTU: begin
                rd = {{(WIDTH-1){1'b0}}, lt_unsigned};
            end
            alu_pkg::FUNC_LU: begin
                rd = rt << (WIDTH / 2);
            end

            // branch compares, result stays zero
            alu_pkg::FUNC_BEQ: begin
                branch    = equal;
                writes_rd = 1'b0;
            end
            alu_pkg::FUNC_BNE: begin
                branch    = !equal;
                writes_rd = 1'b0;
            end
            alu_pkg::FUNC_BLT: begin
                branch    = lt_signed;
                writes_rd = 1'b0;
            end
            alu_pkg::FUNC_BLEQ: begin
                branch    = lt_signed || equal;
                writes_rd = 1'b0;
            end

            alu_pkg::FUNC_MUL, alu_pkg::FUNC_MULU,
            alu_pkg::FUNC_DIV, alu_pkg::FUNC_DIVU: begin
                writes_rd = 1'b0;                 // handled by mul_div_unit
            end
            default: begin
                writes_rd = 1'b0;                 // unknown code
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/mul_div_unit.sv
`timescale 1ns/1ns
`default_nettype none

module mul_div_unit #(
    parameter int WIDTH = 32
) (
    input logic    clk,
    input logic    reset,
    muldiv_if.unit md
);

    localparam int DIV_LATENCY = WIDTH + alu_pkg::DIV_CYCLES_EXTRA;
    localparam int CNT_W       = $clog2(DIV_LATENCY);

    logic [WIDTH-1:0]   hi_q;
    logic [WIDTH-1:0]   lo_q;
    logic               busy_q;
    logic [CNT_W-1:0]   cnt_q;       // steps done so far
    logic [WIDTH-1:0]   rem_q;
    logic [WIDTH-1:0]   quo_q;
    logic [WIDTH-1:0]   dsr_q;
    logic               neg_quo_q;
    logic               neg_rem_q;
    logic               dzero_q;

    logic               is_mul;
    logic               is_div;
    logic               div_signed;
    logic [2*WIDTH-1:0] prod_s;
    logic [2*WIDTH-1:0] prod_u;
    logic               neg_rs;
    logic               neg_rt;
    logic [WIDTH-1:0]   mag_rs;
    logic [WIDTH-1:0]   mag_rt;
    logic [WIDTH-1:0]   step_rem_in;
    logic [WIDTH-1:0]   step_quo_in;
    logic [WIDTH-1:0]   step_dsr;
    logic [WIDTH:0]     shifted;
    logic [WIDTH:0]     diff;
    logic               take;
    logic [WIDTH-1:0]   step_rem;
    logic [WIDTH-1:0]   step_quo;
    logic               stepping;
    logic               fix_cycle;
    logic [WIDTH-1:0]   quo_fixed;
    logic [WIDTH-1:0]   rem_fixed;

    assign is_mul     = md.func == alu_pkg::FUNC_MUL || md.func == alu_pkg::FUNC_MULU;
    assign is_div     = md.func == alu_pkg::FUNC_DIV || md.func == alu_pkg::FUNC_DIVU;
    assign div_signed = md.func == alu_pkg::FUNC_DIV;

    assign prod_s = $signed(md.rs) * $signed(md.rt);
    assign prod_u = md.rs * md.rt;

    // operand magnitudes, most negative value maps to 2**(WIDTH-1)
    assign neg_rs = div_signed && md.rs[WIDTH-1];
    assign neg_rt = div_signed && md.rt[WIDTH-1];
    assign mag_rs = neg_rs ? -md.rs : md.rs;
    assign mag_rt = neg_rt ? -md.rt : md.rt;

    ////////////////////////////////////////////////////////////
    // restoring step, the first one runs in the start cycle
    ////////////////////////////////////////////////////////////

    assign step_rem_in = busy_q ? rem_q : '0;
    assign step_quo_in = busy_q ? quo_q : mag_rs;
    assign step_dsr    = busy_q ? dsr_q : mag_rt;

    assign shifted  = {step_rem_in, step_quo_in[WIDTH-1]};
    assign diff     = shifted - {1'b0, step_dsr};
    assign take     = shifted >= {1'b0, step_dsr};
    assign step_rem = take ? diff[WIDTH-1:0] : shifted[WIDTH-1:0];
    assign step_quo = {step_quo_in[WIDTH-2:0], take};

    assign stepping  = (md.start && is_div) || (busy_q && cnt_q < CNT_W'(WIDTH));
    assign fix_cycle = busy_q && cnt_q == CNT_W'(DIV_LATENCY - 1);

    // divide by zero keeps the all ones quotient
    assign quo_fixed = dzero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
    assign rem_fixed = neg_rem_q ? -rem_q : rem_q; // sign of dividend

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            hi_q   <= '0;
            lo_q   <= '0;
        end else begin
            if (md.start && is_mul) begin
                {hi_q, lo_q} <= (md.func == alu_pkg::FUNC_MUL) ? prod_s : prod_u;
            end
            if (md.start && is_div) begin
                busy_q <= 1'b1;
                cnt_q  <= CNT_W'(1);
            end else if (fix_cycle) begin
                busy_q <= 1'b0;
                hi_q   <= rem_fixed;
                lo_q   <= quo_fixed;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stepping) begin
            rem_q <= step_rem;
            quo_q <= step_quo;
        end
        if (md.start && is_div) begin
            dsr_q     <= mag_rt;
            neg_quo_q <= neg_rs ^ neg_rt;
            neg_rem_q <= neg_rs;
            dzero_q   <= md.rt == '0;
        end
    end

    assign md.busy = busy_q;
    assign md.done = fix_cycle;
    assign md.hi   = hi_q;
    assign md.lo   = lo_q;

    a_no_start_busy : assert property (
        @(posedge clk) disable iff (reset)
        md.start |-> !busy_q
    ) else $error("mul_div_unit: start while divide busy");

    // done must trace back to a divide start a fixed time ago
    a_done_after_start : assert property (
        @(posedge clk) disable iff (reset)
        md.done |-> $past(md.start && is_div, DIV_LATENCY - 1)
    ) else $error("mul_div_unit: done without matching start");

endmodule

`default_nettype wire

//--- hw/execute_core.sv
`timescale 1ns/1ns
`default_nettype none

module execute_core #(
    parameter int WIDTH = 32
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue,
    input  alu_pkg::alu_func_t func,
    input  alu_pkg::reg_idx_t  rs_idx,
    input  alu_pkg::reg_idx_t  rt_idx,
    input  alu_pkg::reg_idx_t  rd_idx,
    input  logic               load,
    input  alu_pkg::reg_idx_t  load_idx,
    input  logic [WIDTH-1:0]   load_data,
    output logic               done,
    output logic [WIDTH-1:0]   result,
    output logic               branch_taken,
    output logic               busy
);

    logic [WIDTH-1:0]  rs_data;
    logic [WIDTH-1:0]  rt_data;
    logic [WIDTH-1:0]  alu_rd;
    logic              alu_branch;
    logic              alu_writes_rd;
    logic [WIDTH-1:0]  wb_data;
    logic              wb_en;
    logic              is_muldiv;
    logic              is_div;
    logic              rf_write;
    alu_pkg::reg_idx_t rf_write_idx;
    logic [WIDTH-1:0]  rf_write_data;
    logic              done_q;
    logic [WIDTH-1:0]  result_q;
    logic              branch_q;

    muldiv_if #(.WIDTH(WIDTH)) md_bus ();

    ////////////////////////////////////////////////////////////
    // operand read and write-back port
    ////////////////////////////////////////////////////////////

    assign rf_write      = wb_en || load;
    assign rf_write_idx  = load ? load_idx : rd_idx;
    assign rf_write_data = load ? load_data : wb_data;

    register_file #(.WIDTH(WIDTH)) u_rf (
        .clk        (clk),
        .reset      (reset),
        .rs_idx     (rs_idx),
        .rt_idx     (rt_idx),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .write      (rf_write),
        .write_idx  (rf_write_idx),
        .write_data (rf_write_data)
    );

    arithmetic_logic_unit #(.WIDTH(WIDTH)) u_alu (
        .func      (func),
        .rs        (rs_data),
        .rt        (rt_data),
        .rd        (alu_rd),
        .branch    (alu_branch),
        .writes_rd (alu_writes_rd)
    );

    // mul and div leave the alu idle
    assign is_muldiv = func inside {alu_pkg::FUNC_MUL, alu_pkg::FUNC_MULU,
                                    alu_pkg::FUNC_DIV, alu_pkg::FUNC_DIVU};
    assign is_div    = func == alu_pkg::FUNC_DIV || func == alu_pkg::FUNC_DIVU;

    assign md_bus.start = issue && is_muldiv;
    assign md_bus.func  = func;
    assign md_bus.rs    = rs_data;
    assign md_bus.rt    = rt_data;

    mul_div_unit #(.WIDTH(WIDTH)) u_muldiv (
        .clk   (clk),
        .reset (reset),
        .md    (md_bus)
    );

    always_comb begin
        case (func)
            alu_pkg::FUNC_MFHI: wb_data = md_bus.hi;
            alu_pkg::FUNC_MFLO: wb_data = md_bus.lo;
            default:            wb_data = alu_rd;
        endcase
    end

    assign wb_en = issue && alu_writes_rd;

    // one cycle ops finish next edge, divide finishes on the unit's done
    always_ff @(posedge clk) begin
        if (reset) begin
            done_q   <= 1'b0;
            result_q <= '0;
            branch_q <= 1'b0;
        end else begin
            done_q   <= (issue && !is_div) || md_bus.done;
            result_q <= wb_en ? wb_data : '0;
            branch_q <= issue && alu_branch;
        end
    end

    assign done         = done_q;
    assign result       = result_q;
    assign branch_taken = branch_q;
    assign busy         = md_bus.busy;

    a_no_port_collision : assert property (
        @(posedge clk) disable iff (reset)
        !(load && wb_en)
    ) else $error("execute_core: load collides with write-back");

    // no stall, so hi/lo reads and new work must wait out the divide
    a_no_issue_busy : assert property (
        @(posedge clk) disable iff (reset)
        issue |-> !md_bus.busy
    ) else $error("execute_core: issue while busy");

endmodule

`default_nettype wire

//--- sim/tb_execute_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_execute_core;

    localparam int WIDTH        = 32;
    localparam int DONE_TIMEOUT = 3 * WIDTH; // in cycles and well past the divide

    logic               clk;
    logic               reset;
    logic               issue;
    alu_pkg::alu_func_t func;
    alu_pkg::reg_idx_t  rs_idx;
    alu_pkg::reg_idx_t  rt_idx;
    alu_pkg::reg_idx_t  rd_idx;
    logic               load;
    alu_pkg::reg_idx_t  load_idx;
    logic [WIDTH-1:0]   load_data;
    logic               done;
    logic [WIDTH-1:0]   result;
    logic               branch_taken;
    logic               busy;

    logic [WIDTH-1:0]   shadow [32];  // expected register file
    logic [WIDTH-1:0]   shadow_hi;
    logic [WIDTH-1:0]   shadow_lo;
    logic [31:0]        lfsr;
    string              test_name;
    logic [WIDTH-1:0]   exp_result;
    logic               exp_branch;
    logic               exp_div;
    alu_pkg::reg_idx_t  chk_idx;      // register looked at when done pulses
    logic [WIDTH-1:0]   reg_expected;
    logic [WIDTH-1:0]   reg_actual;
    int                 errors;

    execute_core #(.WIDTH(WIDTH)) u_dut (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .func         (func),
        .rs_idx       (rs_idx),
        .rt_idx       (rt_idx),
        .rd_idx       (rd_idx),
        .load         (load),
        .load_idx     (load_idx),
        .load_data    (load_data),
        .done         (done),
        .result       (result),
        .branch_taken (branch_taken),
        .busy         (busy)
    );

    always #2 clk = ~clk;

    assign reg_expected = shadow[chk_idx];
    assign reg_actual   = u_dut.u_rf.regs[chk_idx];

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    a_reset_state : assert property (@(posedge clk)
        reset |=> !done && !busy && !branch_taken && result == '0)
    else begin
        errors++;
        $display("Error: %s expected all low, actual done %b busy %b branch %b result %h",
                 test_name, $sampled(done), $sampled(busy), $sampled(branch_taken),
                 $sampled(result));
    end

    a_done : assert property (@(posedge clk) disable iff (reset)
        issue && !exp_div |=> done)
    else begin
        errors++;
        $display("Error: %s done expected 1 actual 0", test_name);
    end

    a_result : assert property (@(posedge clk) disable iff (reset)
        issue && !exp_div |=> result == exp_result)
    else begin
        errors++;
        $display("Error: %s result expected %h actual %h", test_name, exp_result,
                 $sampled(result));
    end

    a_branch : assert property (@(posedge clk) disable iff (reset)
        issue |=> branch_taken == exp_branch)
    else begin
        errors++;
        $display("Error: %s branch_taken expected %b actual %b", test_name, exp_branch,
                 $sampled(branch_taken));
    end

    a_div_busy : assert property (@(posedge clk) disable iff (reset)
        issue && exp_div |=> busy)
    else begin
        errors++;
        $display("Error: %s busy expected 1 actual 0", test_name);
    end

    // divide finishes with busy dropped and nothing on result
    a_div_done : assert property (@(posedge clk) disable iff (reset)
        done && exp_div |-> !busy && result == '0)
    else begin
        errors++;
        $display("Error: %s busy/result expected 0/0 actual %b/%h", test_name,
                 $sampled(busy), $sampled(result));
    end

    a_reg : assert property (@(posedge clk) disable iff (reset)
        done |-> reg_actual == reg_expected)
    else begin
        errors++;
        $display("Error: %s r%0d expected %h actual %h", test_name, chk_idx, reg_expected,
                 reg_actual);
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers and reference model
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [WIDTH-1:0] random_bits(input int n);
        logic [WIDTH-1:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            w[i] = lfsr[0];
        end
        return w;
    endfunction

    function automatic int random_src();
        return 1 + int'(random_bits(3)); // r1..r8 hold random data
    endfunction

    task automatic model_instr(input alu_pkg::alu_func_t f, input int s, input int t,
                               input int d);
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [WIDTH-1:0] r;
        logic             wr;
        logic signed [2*WIDTH-1:0] sa;
        logic signed [2*WIDTH-1:0] sb;
        logic signed [2*WIDTH-1:0] q;
        logic signed [2*WIDTH-1:0] rm;
        a = shadow[s];
        b = shadow[t];
        r = '0;
        wr = 1'b1;
        exp_branch = 1'b0;
        exp_div = 1'b0;
        case (f)
            alu_pkg::FUNC_SLL:  r = a << b[4:0];
            alu_pkg::FUNC_SRL:  r = a >> b[4:0];
            alu_pkg::FUNC_SRA:  r = $signed(a) >>> b[4:0];
            alu_pkg::FUNC_MFHI: r = shadow_hi;
            alu_pkg::FUNC_MFLO: r = shadow_lo;
            alu_pkg::FUNC_ADD, alu_pkg::FUNC_ADDU: r = a + b;
            alu_pkg::FUNC_SUB, alu_pkg::FUNC_SUBU: r = a - b;
            alu_pkg::FUNC_AND:  r = a & b;
            alu_pkg::FUNC_OR:   r = a | b;
            alu_pkg::FUNC_XOR:  r = a ^ b;
            alu_pkg::FUNC_NOR:  r = ~(a | b);
            alu_pkg::FUNC_SLT:  r = WIDTH'($signed(a) < $signed(b));
            alu_pkg::FUNC_SLTU: r = WIDTH'(a < b);
            alu_pkg::FUNC_LU:   r = b << (WIDTH / 2);
            alu_pkg::FUNC_BEQ, alu_pkg::FUNC_BNE, alu_pkg::FUNC_BLT, alu_pkg::FUNC_BLEQ: begin
                wr = 1'b0;
                exp_branch = (f == alu_pkg::FUNC_BEQ)  ? a == b :
                             (f == alu_pkg::FUNC_BNE)  ? a != b :
                             (f == alu_pkg::FUNC_BLT)  ? $signed(a) < $signed(b) :
                                                         $signed(a) <= $signed(b);
            end
            alu_pkg::FUNC_MUL: begin
                wr = 1'b0;
                {shadow_hi, shadow_lo} = {{WIDTH{a[WIDTH-1]}}, a} * {{WIDTH{b[WIDTH-1]}}, b};
            end
            alu_pkg::FUNC_MULU: begin
                wr = 1'b0;
                {shadow_hi, shadow_lo} = {{WIDTH{1'b0}}, a} * {{WIDTH{1'b0}}, b};
            end
            alu_pkg::FUNC_DIV, alu_pkg::FUNC_DIVU: begin
                wr = 1'b0;
                exp_div = 1'b1;
                // double width so the most negative value over -1 stays in range
                if (f == alu_pkg::FUNC_DIV) begin
                    sa = {{WIDTH{a[WIDTH-1]}}, a};
                    sb = {{WIDTH{b[WIDTH-1]}}, b};
                end else begin
                    sa = {{WIDTH{1'b0}}, a};
                    sb = {{WIDTH{1'b0}}, b};
                end
                if (b == '0) begin
                    shadow_lo = '1;
                    shadow_hi = a;
                end else begin
                    q = sa / sb;  // truncates toward zero
                    rm = sa % sb; // takes the sign of the dividend
                    shadow_lo = q[WIDTH-1:0];
                    shadow_hi = rm[WIDTH-1:0];
                end
            end
            default: wr = 1'b0;
        endcase
        exp_result = wr ? r : '0;
        chk_idx = alu_pkg::reg_idx_t'(d);
        if (wr && d != 0) begin
            shadow[d] = r;
        end
    endtask

    task automatic load_reg(input int idx, input logic [WIDTH-1:0] value);
        @(negedge clk);
        load = 1'b1;
        load_idx = alu_pkg::reg_idx_t'(idx);
        load_data = value;
        if (idx != 0) begin
            shadow[idx] = value;
        end
        @(negedge clk);
        load = 1'b0;
    endtask

    task automatic run_instr(input string name, input alu_pkg::alu_func_t f, input int s,
                             input int t, input int d);
        int waited;
        @(negedge clk);
        test_name = name;
        model_instr(f, s, t, d);
        issue = 1'b1;
        func = f;
        rs_idx = alu_pkg::reg_idx_t'(s);
        rt_idx = alu_pkg::reg_idx_t'(t);
        rd_idx = alu_pkg::reg_idx_t'(d);
        @(negedge clk);
        issue = 1'b0;
        waited = 0;
        while (!done && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            errors++;
            $display("%s never signalled done within %0d cycles", name, DONE_TIMEOUT);
        end
    endtask

    task automatic muldiv_then_read(input string name, input alu_pkg::alu_func_t f,
                                    input int s, input int t);
        run_instr(name, f, s, t, 9);
        run_instr({name, " lo"}, alu_pkg::FUNC_MFLO, 0, 0, 28);
        run_instr({name, " hi"}, alu_pkg::FUNC_MFHI, 0, 0, 29);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        alu_pkg::alu_func_t basic_ops [11];
        alu_pkg::alu_func_t branch_ops [4];
        basic_ops = '{alu_pkg::FUNC_ADD, alu_pkg::FUNC_ADDU, alu_pkg::FUNC_SUB,
                      alu_pkg::FUNC_SUBU, alu_pkg::FUNC_AND, alu_pkg::FUNC_OR,
                      alu_pkg::FUNC_XOR, alu_pkg::FUNC_NOR, alu_pkg::FUNC_SLL,
                      alu_pkg::FUNC_SRL, alu_pkg::FUNC_SRA};
        branch_ops = '{alu_pkg::FUNC_BEQ, alu_pkg::FUNC_BNE, alu_pkg::FUNC_BLT,
                       alu_pkg::FUNC_BLEQ};
        clk = 1'b0;
        reset = 1'b1;
        issue = 1'b0;
        func = alu_pkg::FUNC_SLL;
        rs_idx = '0;
        rt_idx = '0;
        rd_idx = '0;
        load = 1'b0;
        load_idx = '0;
        load_data = '0;
        lfsr = 32'h92a7_189a;
        errors = 0;
        test_name = "reset";
        exp_result = '0;
        exp_branch = 1'b0;
        exp_div = 1'b0;
        chk_idx = '0;
        shadow_hi = '0;
        shadow_lo = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // hi/lo start cleared before plain alu ops on random data
        run_instr("mfhi after reset", alu_pkg::FUNC_MFHI, 0, 0, 28);
        run_instr("mflo after reset", alu_pkg::FUNC_MFLO, 0, 0, 29);
        for (int i = 1; i <= 8; i++) begin
            load_reg(i, random_bits(WIDTH));
        end
        for (int round = 0; round < 3; round++) begin
            foreach (basic_ops[k]) begin
                run_instr(basic_ops[k].name(), basic_ops[k], random_src(), random_src(),
                          9 + k % 6);
            end
        end

        // compares and lu on edge values
        load_reg(20, {1'b1, {(WIDTH-1){1'b0}}});  // most negative
        load_reg(21, {1'b0, {(WIDTH-1){1'b1}}});  // most positive
        load_reg(22, {1'b0, {(WIDTH-1){1'b1}}});
        run_instr("slt min max", alu_pkg::FUNC_SLT, 20, 21, 23);
        run_instr("sltu min max", alu_pkg::FUNC_SLTU, 20, 21, 24);
        run_instr("slt equal", alu_pkg::FUNC_SLT, 21, 22, 25);
        for (int i = 0; i < 4; i++) begin
            run_instr("slt random", alu_pkg::FUNC_SLT, random_src(), random_src(), 15);
            run_instr("sltu random", alu_pkg::FUNC_SLTU, random_src(), random_src(), 16);
        end
        run_instr("lu", alu_pkg::FUNC_LU, 0, 21, 24);
        run_instr("add after slt and lu", alu_pkg::FUNC_ADD, 23, 24, 25);

        foreach (branch_ops[k]) begin
            run_instr({branch_ops[k].name(), " equal"}, branch_ops[k], 21, 22, 9);
            run_instr({branch_ops[k].name(), " smaller"}, branch_ops[k], 20, 21, 9);
            run_instr({branch_ops[k].name(), " larger"}, branch_ops[k], 21, 20, 9);
        end

        load_reg(26, -WIDTH'(7));
        load_reg(27, WIDTH'(3));
        load_reg(30, '1);
        muldiv_then_read("mul negative", alu_pkg::FUNC_MUL, 26, 27);
        muldiv_then_read("mulu negative", alu_pkg::FUNC_MULU, 26, 27);
        muldiv_then_read("mul min max", alu_pkg::FUNC_MUL, 20, 21);
        muldiv_then_read("div negative", alu_pkg::FUNC_DIV, 26, 27);
        muldiv_then_read("div by negative", alu_pkg::FUNC_DIV, 27, 26);
        muldiv_then_read("divu large", alu_pkg::FUNC_DIVU, 26, 27);
        muldiv_then_read("div by zero", alu_pkg::FUNC_DIV, 26, 0);
        muldiv_then_read("divu by zero", alu_pkg::FUNC_DIVU, 21, 0);
        muldiv_then_read("div min by -1", alu_pkg::FUNC_DIV, 20, 30);
        for (int i = 0; i < 3; i++) begin
            muldiv_then_read("mul random", alu_pkg::FUNC_MUL, random_src(), random_src());
            muldiv_then_read("mulu random", alu_pkg::FUNC_MULU, random_src(), random_src());
            muldiv_then_read("div random", alu_pkg::FUNC_DIV, random_src(), random_src());
            muldiv_then_read("divu random", alu_pkg::FUNC_DIVU, random_src(), random_src());
        end

        // r0 stays zero and unknown codes only give done
        load_reg(0, random_bits(WIDTH));
        run_instr("write r0", alu_pkg::FUNC_ADD, 1, 2, 0);
        run_instr("read r0", alu_pkg::FUNC_OR, 0, 0, 10);
        run_instr("unknown 00011", alu_pkg::alu_func_t'(5'b00011), 1, 2, 11);
        run_instr("unknown 00110", alu_pkg::alu_func_t'(5'b00110), 3, 4, 11);
        run_instr("unknown 10100", alu_pkg::alu_func_t'(5'b10100), 5, 6, 11);

        repeat (2) @(negedge clk);
        $display("%0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hw/alu_pkg.sv
hw/muldiv_if.sv
hw/register_file.sv
hw/arithmetic_logic_unit.sv
hw/mul_div_unit.sv
hw/execute_core.sv
sim/tb_execute_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_execute_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_execute_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$out"; then
    exit 0
fi
echo "simulation reported failures"
exit 1
